//--- verilog/axi_axil_pkg.sv
package axi_axil_pkg;

  localparam int ADDR_W = 20;
  localparam int DATA_W = 16;
  localparam int STRB_W = DATA_W / 8;
  localparam int ID_W   = 4;

  typedef enum logic [1:0] {
    FIXED = 2'b00,
    INCR  = 2'b01,
    WRAP  = 2'b10
  } burst_e;

  // larger code is the worse response
  typedef enum logic [1:0] {
    OKAY   = 2'b00,
    EXOKAY = 2'b01,
    SLVERR = 2'b10,
    DECERR = 2'b11
  } resp_e;

  typedef enum logic [1:0] {
    WR_IDLE,
    WR_BURST,
    WR_RESP
  } wr_state_e;

  typedef enum logic {
    RD_IDLE,
    RD_BURST
  } rd_state_e;

  typedef struct packed {
    logic [ID_W-1:0]   id;
    logic [ADDR_W-1:0] addr;
    logic [7:0]        len;
    logic [2:0]        size;
    burst_e            burst;
  } axi_ax_t;

  typedef struct packed {
    logic [DATA_W-1:0] data;
    logic [STRB_W-1:0] strb;
    logic              last;
  } axi_w_t;

  typedef struct packed {
    logic [ID_W-1:0] id;
    resp_e           resp;
  } axi_b_t;

  typedef struct packed {
    logic [ID_W-1:0]   id;
    logic [DATA_W-1:0] data;
    resp_e             resp;
    logic              last;
  } axi_r_t;

  typedef struct packed {
    logic [DATA_W-1:0] data;
    logic [STRB_W-1:0] strb;
  } axil_w_t;

  typedef struct packed {
    logic [DATA_W-1:0] data;
    resp_e             resp;
  } axil_r_t;

  function automatic logic [ADDR_W-1:0] next_addr(
    input logic [ADDR_W-1:0] addr,
    input logic [2:0]        size,
    input logic [7:0]        len,
    input burst_e            burst
  );
    logic [ADDR_W-1:0] step;
    logic [ADDR_W-1:0] incr;
    logic [ADDR_W-1:0] mask;
    step = ADDR_W'(1) << size;
    incr = addr + step;
    // window of len+1 beats, a power of two for a legal wrap burst
    mask = ((ADDR_W'(len) + ADDR_W'(1)) << size) - ADDR_W'(1);
    case (burst)
      FIXED:   next_addr = addr;
      WRAP:    next_addr = (addr & ~mask) | (incr & mask);
      default: next_addr = incr;
    endcase
  endfunction

endpackage

//--- verilog/axi_axil_wr.sv
module axi_axil_wr
  import axi_axil_pkg::*;
(
  input  logic              clk,
  input  logic              rst_n,

  input  axi_ax_t           aw,
  input  logic              aw_valid,
  output logic              aw_ready,

  input  axi_w_t            w,
  input  logic              w_valid,
  output logic              w_ready,

  output axi_b_t            b,
  output logic              b_valid,
  input  logic              b_ready,

  output logic [ADDR_W-1:0] lite_aw_addr,
  output logic              lite_aw_valid,
  input  logic              lite_aw_ready,

  output axil_w_t           lite_w,
  output logic              lite_w_valid,
  input  logic              lite_w_ready,

  input  resp_e             lite_b_resp,
  input  logic              lite_b_valid,
  output logic              lite_b_ready
);

  wr_state_e state;

  axi_ax_t           req;
  logic [ADDR_W-1:0] addr_q;
  axil_w_t           beat_q;
  logic              beat_full;
  logic              aw_done;
  logic              w_done;
  logic              last_taken;
  logic [8:0]        issued;
  logic [8:0]        resp_cnt;
  resp_e             worst;

  logic aw_fire;
  logic w_fire;
  logic lite_aw_fire;
  logic lite_w_fire;
  logic lite_b_fire;
  logic beat_done;
  logic issue_done;

  // ready waits for valid so nothing is advertised before a request
  assign aw_ready = aw_valid && (state == WR_IDLE);
  assign aw_fire  = aw_valid && aw_ready;

  // beat register takes a new beat when empty or draining this cycle
  assign w_ready = (state == WR_BURST) && !last_taken && (!beat_full || beat_done);
  assign w_fire  = w_valid && w_ready;

  assign lite_aw_addr  = addr_q;
  assign lite_aw_valid = beat_full && !aw_done;
  assign lite_aw_fire  = lite_aw_valid && lite_aw_ready;

  assign lite_w       = beat_q;
  assign lite_w_valid = beat_full && !w_done;
  assign lite_w_fire  = lite_w_valid && lite_w_ready;

  // both lite channels accepted, now or earlier
  assign beat_done = beat_full && (aw_done || lite_aw_fire) && (w_done || lite_w_fire);

  assign lite_b_ready = (state == WR_BURST) || (state == WR_RESP);
  assign lite_b_fire  = lite_b_valid && lite_b_ready;

  assign issue_done = last_taken && !beat_full;

  assign b_valid = (state == WR_RESP);
  assign b       = '{id: req.id, resp: worst};

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state      <= WR_IDLE;
      beat_full  <= 1'b0;
      aw_done    <= 1'b0;
      w_done     <= 1'b0;
      last_taken <= 1'b0;
      issued     <= '0;
      resp_cnt   <= '0;
      worst      <= OKAY;
    end else begin
      case (state)
        WR_IDLE: begin
          if (aw_fire) begin
            state      <= WR_BURST;
            last_taken <= 1'b0;
            issued     <= '0;
            resp_cnt   <= '0;
            worst      <= OKAY;
          end
        end
        WR_BURST: begin
          // every issued beat has its response back
          if (issue_done && (resp_cnt == issued)) begin
            state <= WR_RESP;
          end
        end
        WR_RESP: begin
          if (b_ready) begin
            state <= WR_IDLE;
          end
        end
        default: state <= WR_IDLE;
      endcase

      if (w_fire) begin
        beat_full <= 1'b1;
        if (w.last) begin
          last_taken <= 1'b1;
        end
      end else if (beat_done) begin
        beat_full <= 1'b0;
      end

      if (beat_done) begin
        aw_done <= 1'b0;
        w_done  <= 1'b0;
        issued  <= issued + 9'd1;
      end else begin
        if (lite_aw_fire) begin
          aw_done <= 1'b1;
        end
        if (lite_w_fire) begin
          w_done <= 1'b1;
        end
      end

      if (lite_b_fire) begin
        resp_cnt <= resp_cnt + 9'd1;
        if (lite_b_resp > worst) begin
          worst <= lite_b_resp;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (aw_fire) begin
      req    <= aw;
      addr_q <= aw.addr;
    end else if (beat_done) begin
      addr_q <= next_addr(addr_q, req.size, req.len, req.burst);
    end

    if (w_fire) begin
      beat_q <= '{data: w.data, strb: w.strb};
    end
  end

endmodule

//--- verilog/axi_axil_rd.sv
module axi_axil_rd
  import axi_axil_pkg::*;
(
  input  logic              clk,
  input  logic              rst_n,

  input  axi_ax_t           ar,
  input  logic              ar_valid,
  output logic              ar_ready,

  output axi_r_t            r,
  output logic              r_valid,
  input  logic              r_ready,

  output logic [ADDR_W-1:0] lite_ar_addr,
  output logic              lite_ar_valid,
  input  logic              lite_ar_ready,

  input  axil_r_t           lite_r,
  input  logic              lite_r_valid,
  output logic              lite_r_ready
);

  rd_state_e state;

  axi_ax_t           req;
  logic [ADDR_W-1:0] addr_q;
  logic [8:0]        ar_cnt;
  logic [8:0]        r_cnt;

  logic ar_fire;
  logic lite_ar_fire;
  logic r_fire;
  logic r_last;
  logic in_burst;

  assign in_burst = (state == RD_BURST);

  assign ar_ready = ar_valid && (state == RD_IDLE);
  assign ar_fire  = ar_valid && ar_ready;

  // addresses go out independently of returning data
  assign lite_ar_addr  = addr_q;
  assign lite_ar_valid = in_burst && (ar_cnt <= {1'b0, req.len});
  assign lite_ar_fire  = lite_ar_valid && lite_ar_ready;

  // read data passes straight through, tagged with the burst id
  assign r_last       = (r_cnt == {1'b0, req.len});
  assign r_valid      = in_burst && lite_r_valid;
  assign lite_r_ready = in_burst && r_ready;
  assign r_fire       = r_valid && r_ready;

  assign r = '{
    id:   req.id,
    data: lite_r.data,
    resp: lite_r.resp,
    last: r_last
  };

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state  <= RD_IDLE;
      ar_cnt <= '0;
      r_cnt  <= '0;
    end else begin
      case (state)
        RD_IDLE: begin
          if (ar_fire) begin
            state  <= RD_BURST;
            ar_cnt <= '0;
            r_cnt  <= '0;
          end
        end
        RD_BURST: begin
          if (lite_ar_fire) begin
            ar_cnt <= ar_cnt + 9'd1;
          end
          if (r_fire) begin
            r_cnt <= r_cnt + 9'd1;
            if (r_last) begin
              state <= RD_IDLE;
            end
          end
        end
        default: state <= RD_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (ar_fire) begin
      req    <= ar;
      addr_q <= ar.addr;
    end else if (lite_ar_fire) begin
      addr_q <= next_addr(addr_q, req.size, req.len, req.burst);
    end
  end

endmodule

//--- verilog/axi_axil_adapter.sv
module axi_axil_adapter
  import axi_axil_pkg::*;
(
  input  logic              clk,
  input  logic              rst_n,

  // AXI slave side
  input  axi_ax_t           aw,
  input  logic              aw_valid,
  output logic              aw_ready,
  input  axi_w_t            w,
  input  logic              w_valid,
  output logic              w_ready,
  output axi_b_t            b,
  output logic              b_valid,
  input  logic              b_ready,
  input  axi_ax_t           ar,
  input  logic              ar_valid,
  output logic              ar_ready,
  output axi_r_t            r,
  output logic              r_valid,
  input  logic              r_ready,

  // AXI-Lite master side
  output logic [ADDR_W-1:0] lite_aw_addr,
  output logic              lite_aw_valid,
  input  logic              lite_aw_ready,
  output axil_w_t           lite_w,
  output logic              lite_w_valid,
  input  logic              lite_w_ready,
  input  resp_e             lite_b_resp,
  input  logic              lite_b_valid,
  output logic              lite_b_ready,
  output logic [ADDR_W-1:0] lite_ar_addr,
  output logic              lite_ar_valid,
  input  logic              lite_ar_ready,
  input  axil_r_t           lite_r,
  input  logic              lite_r_valid,
  output logic              lite_r_ready
);

  axi_axil_wr u_wr (
    .clk          (clk),
    .rst_n        (rst_n),
    .aw           (aw),
    .aw_valid     (aw_valid),
    .aw_ready     (aw_ready),
    .w            (w),
    .w_valid      (w_valid),
    .w_ready      (w_ready),
    .b            (b),
    .b_valid      (b_valid),
    .b_ready      (b_ready),
    .lite_aw_addr (lite_aw_addr),
    .lite_aw_valid(lite_aw_valid),
    .lite_aw_ready(lite_aw_ready),
    .lite_w       (lite_w),
    .lite_w_valid (lite_w_valid),
    .lite_w_ready (lite_w_ready),
    .lite_b_resp  (lite_b_resp),
    .lite_b_valid (lite_b_valid),
    .lite_b_ready (lite_b_ready)
  );

  axi_axil_rd u_rd (
    .clk          (clk),
    .rst_n        (rst_n),
    .ar           (ar),
    .ar_valid     (ar_valid),
    .ar_ready     (ar_ready),
    .r            (r),
    .r_valid      (r_valid),
    .r_ready      (r_ready),
    .lite_ar_addr (lite_ar_addr),
    .lite_ar_valid(lite_ar_valid),
    .lite_ar_ready(lite_ar_ready),
    .lite_r       (lite_r),
    .lite_r_valid (lite_r_valid),
    .lite_r_ready (lite_r_ready)
  );

endmodule

//--- verification/axi_axil_adapter_chk.sv
module axi_axil_adapter_chk
  import axi_axil_pkg::*;
(
  input logic              clk, rst_n,
  input logic              lite_aw_valid, lite_aw_ready, lite_w_valid, lite_w_ready,
  input logic              lite_ar_valid, b_valid, b_ready, r_valid, r_ready,
  input logic [ADDR_W-1:0] lite_aw_addr,
  input axil_w_t           lite_w,
  input axi_b_t            b,
  input axi_r_t            r
);

  a_reset_quiet: assert property (@(posedge clk) !rst_n |=>
    !(lite_aw_valid || lite_w_valid || lite_ar_valid || b_valid || r_valid))
    else $error("valid output raised during reset");

  // a raised valid holds with its payload until the transfer
  a_lite_aw_hold: assert property (@(posedge clk) disable iff (!rst_n)
    lite_aw_valid && !lite_aw_ready |=> lite_aw_valid && $stable(lite_aw_addr))
    else $error("lite_aw_valid or lite_aw_addr changed before acceptance");
  a_lite_w_hold: assert property (@(posedge clk) disable iff (!rst_n)
    lite_w_valid && !lite_w_ready |=> lite_w_valid && $stable(lite_w))
    else $error("lite_w_valid or lite_w changed before acceptance");
  a_b_hold: assert property (@(posedge clk) disable iff (!rst_n)
    b_valid && !b_ready |=> b_valid && $stable(b))
    else $error("b_valid or b changed before acceptance");
  a_r_hold: assert property (@(posedge clk) disable iff (!rst_n)
    r_valid && !r_ready |=> r_valid && $stable(r))
    else $error("r_valid or r changed before acceptance");

endmodule

bind axi_axil_adapter axi_axil_adapter_chk u_chk (.*);

//--- verification/axi_axil_monitor.sv
module axi_axil_monitor
  import axi_axil_pkg::*;
(
  input logic              clk, rst_n, done,
  input axi_ax_t           aw, ar,
  input axi_w_t            w,
  input axi_b_t            b,
  input axi_r_t            r,
  input axil_w_t           lite_w,
  input logic [ADDR_W-1:0] lite_aw_addr, lite_ar_addr,
  input logic              aw_valid, aw_ready, w_valid, w_ready, b_valid, b_ready,
  input logic              ar_valid, ar_ready, r_valid, r_ready,
  input logic              lite_aw_valid, lite_aw_ready, lite_w_valid, lite_w_ready,
  input logic              lite_b_ready, lite_ar_valid, lite_ar_ready,
  input logic              lite_r_ready,
  output int               mismatches, failures
);

  logic [7:0]        mem [logic [ADDR_W-1:0]];
  logic [ADDR_W-1:0] wr_addr_q[$], mem_addr_q[$], rd_addr_q[$];
  axil_w_t           lite_w_q[$];
  axi_b_t            b_q[$];
  axi_r_t            r_q[$];
  logic              seen_req = 1'b0;
  logic [ADDR_W-1:0] a;
  resp_e             worst;
  axi_b_t            exp_b;
  axi_r_t            exp_r;
  axil_w_t           exp_w;

  initial begin
    mismatches = 0;
    failures = 0;
  end

  // untouched memory reads back a pattern of its own address
  function automatic logic [7:0] model_byte(input logic [ADDR_W-1:0] x);
    if (mem.exists(x)) return mem[x];
    return x[7:0] ^ x[15:8] ^ {4'h5, x[19:16]};
  endfunction

  function automatic resp_e resp_of(input logic [ADDR_W-1:0] x);
    return (x[ADDR_W-1 -: 4] == 4'hF) ? SLVERR : OKAY;
  endfunction

  // burst address rule written out by window arithmetic
  function automatic logic [ADDR_W-1:0] step_addr(input axi_ax_t req,
                                                  input logic [ADDR_W-1:0] x);
    int bytes;
    int total;
    int base;
    bytes = 1 << req.size;
    total = (int'(req.len) + 1) * bytes;
    base = (int'(x) / total) * total;
    if (req.burst == FIXED) return x;
    if (req.burst == WRAP && int'(x) + bytes >= base + total) return ADDR_W'(base);
    return ADDR_W'(int'(x) + bytes);
  endfunction

  task automatic check_value(input string name, input logic [63:0] exp, input logic [63:0] act);
    if (exp !== act) begin
      mismatches++;
      $display("Mismatch %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic report_failure(input string what);
    failures++;
    $display("Error: %s", what);
  endtask

  always @(posedge clk) begin
    if (aw_valid || ar_valid) seen_req = 1'b1;
    if (rst_n && !seen_req && (aw_ready || w_ready || b_valid || ar_ready || r_valid ||
        lite_aw_valid || lite_w_valid || lite_b_ready || lite_ar_valid || lite_r_ready))
      report_failure("DUT raised a valid or ready output before the first request");

    if (aw_valid && aw_ready) begin
      a = aw.addr;
      worst = OKAY;
      for (int i = 0; i <= int'(aw.len); i++) begin
        wr_addr_q.push_back(a);
        mem_addr_q.push_back(a);
        if (resp_of(a) > worst) worst = resp_of(a);
        a = step_addr(aw, a);
      end
      exp_b.id = aw.id;
      exp_b.resp = worst;
      b_q.push_back(exp_b);
    end
    if (w_valid && w_ready) begin
      if (mem_addr_q.size() == 0) begin
        report_failure("W beat accepted outside a write burst");
      end else begin
        a = mem_addr_q.pop_front();
        a[0] = 1'b0;
        if (w.strb[0]) mem[a] = w.data[7:0];
        if (w.strb[1]) mem[a | ADDR_W'(1)] = w.data[15:8];
        exp_w.data = w.data;
        exp_w.strb = w.strb;
        lite_w_q.push_back(exp_w);
      end
    end
    if (lite_aw_valid && lite_aw_ready) begin
      if (wr_addr_q.size() == 0) report_failure("extra AXI-Lite write address");
      else check_value("lite_aw_addr", 64'(wr_addr_q.pop_front()), 64'(lite_aw_addr));
    end
    if (lite_w_valid && lite_w_ready) begin
      if (lite_w_q.size() == 0) report_failure("extra AXI-Lite write data");
      else check_value("lite_w", 64'(lite_w_q.pop_front()), 64'(lite_w));
    end
    if (b_valid && b_ready) begin
      if (b_q.size() == 0) report_failure("extra B response");
      else check_value("b", 64'(b_q.pop_front()), 64'(b));
    end

    if (ar_valid && ar_ready) begin
      a = ar.addr;
      for (int i = 0; i <= int'(ar.len); i++) begin
        rd_addr_q.push_back(a);
        exp_r.id = ar.id;
        exp_r.data = {model_byte(a | ADDR_W'(1)), model_byte(a & ~ADDR_W'(1))};
        exp_r.resp = resp_of(a);
        exp_r.last = (i == int'(ar.len));
        r_q.push_back(exp_r);
        a = step_addr(ar, a);
      end
    end
    if (lite_ar_valid && lite_ar_ready) begin
      if (rd_addr_q.size() == 0) report_failure("extra AXI-Lite read address");
      else check_value("lite_ar_addr", 64'(rd_addr_q.pop_front()), 64'(lite_ar_addr));
    end
    if (r_valid && r_ready) begin
      if (r_q.size() == 0) report_failure("extra R beat");
      else check_value("r", 64'(r_q.pop_front()), 64'(r));
    end
  end

  always @(posedge done) begin
    if (wr_addr_q.size() + lite_w_q.size() + b_q.size() + rd_addr_q.size() + r_q.size() != 0)
      report_failure($sformatf("transfers missing at end: aw %0d w %0d b %0d ar %0d r %0d",
        wr_addr_q.size(), lite_w_q.size(), b_q.size(), rd_addr_q.size(), r_q.size()));
  end

endmodule

//--- verification/axi_axil_adapter_tb.sv
module axi_axil_adapter_tb
  import axi_axil_pkg::*;
();

  logic              clk = 1'b0;
  logic              rst_n = 1'b0;
  logic              done = 1'b0;
  axi_ax_t           aw = '0;
  axi_ax_t           ar = '0;
  axi_w_t            w = '0;
  axil_r_t           lite_r = '0;
  resp_e             lite_b_resp = OKAY;
  logic              aw_valid = 1'b0, w_valid = 1'b0, ar_valid = 1'b0;
  logic              b_ready = 1'b0, r_ready = 1'b0, lite_b_valid = 1'b0, lite_r_valid = 1'b0;
  logic              lite_aw_ready = 1'b0, lite_w_ready = 1'b0, lite_ar_ready = 1'b0;
  logic              aw_ready, w_ready, b_valid, ar_ready, r_valid;
  logic              lite_aw_valid, lite_w_valid, lite_b_ready, lite_ar_valid, lite_r_ready;
  axi_b_t            b;
  axi_r_t            r;
  axil_w_t           lite_w;
  logic [ADDR_W-1:0] lite_aw_addr, lite_ar_addr;
  int                mismatches, failures;

  logic [15:0]       lfsr = 16'd49;
  logic [7:0]        mem [logic [ADDR_W-1:0]];
  logic [ADDR_W-1:0] waddr_q[$];
  axil_w_t           wdata_q[$];
  resp_e             b_pending[$];
  axil_r_t           r_pending[$];
  logic [ADDR_W-1:0] wa;
  axil_w_t           wd;
  axil_r_t           rd_beat;

  axi_axil_adapter DUT (.*);
  axi_axil_monitor u_monitor (.*);

  initial begin
    forever #10 clk = ~clk;
  end

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);
      v = {v[30:0], lfsr[0]};
    end
    return v;
  endfunction

  function automatic logic [7:0] byte_at(input logic [ADDR_W-1:0] x);
    if (mem.exists(x)) return mem[x];
    return x[7:0] ^ x[15:8] ^ {4'h5, x[19:16]};
  endfunction

  task automatic make_req(output axi_ax_t req);
    logic [1:0] kind;
    logic [3:0] nib;
    kind = 2'(rand_bits(2));
    nib = 4'(rand_bits(4));
    if (nib == 4'hF) nib = 4'h0;
    // error nibble about one request in eight
    if (rand_bits(3) == 0) nib = 4'hF;
    req.id = ID_W'(rand_bits(ID_W));
    req.size = 3'(rand_bits(1));
    req.addr = {nib, 16'(rand_bits(16))};
    if (req.size == 3'd1) req.addr[0] = 1'b0;
    req.burst = (kind == 2'd0) ? FIXED : ((kind == 2'd2) ? WRAP : INCR);
    if (req.burst == WRAP) req.len = 8'((2 << (rand_bits(2) % 3)) - 1);
    else req.len = 8'(rand_bits(3));
  endtask

  task automatic write_burst(input axi_ax_t req);
    int gap;
    @(negedge clk);
    aw = req;
    aw_valid = 1'b1;
    @(posedge clk);
    while (!aw_ready) @(posedge clk);
    @(negedge clk);
    aw_valid = 1'b0;
    for (int i = 0; i <= int'(req.len); i++) begin
      gap = (rand_bits(2) == 0) ? int'(rand_bits(2)) : 0;
      if (gap > 0) begin
        w_valid = 1'b0;
        repeat (gap) @(negedge clk);
      end
      w = '{data: 16'(rand_bits(16)), strb: 2'(rand_bits(2)), last: (i == int'(req.len))};
      w_valid = 1'b1;
      @(posedge clk);
      while (!w_ready) @(posedge clk);
      @(negedge clk);
    end
    w_valid = 1'b0;
    @(posedge clk);
    while (!(b_valid && b_ready)) @(posedge clk);
  endtask

  task automatic read_burst(input axi_ax_t req);
    @(negedge clk);
    ar = req;
    ar_valid = 1'b1;
    @(posedge clk);
    while (!ar_ready) @(posedge clk);
    @(negedge clk);
    ar_valid = 1'b0;
    @(posedge clk);
    while (!(r_valid && r_ready && r.last)) @(posedge clk);
  endtask

  // readies low about a quarter of the time
  always @(negedge clk) begin
    b_ready = rand_bits(2) != 0;
    r_ready = rand_bits(2) != 0;
    lite_aw_ready = rand_bits(2) != 0;
    lite_w_ready = rand_bits(2) != 0;
    lite_ar_ready = rand_bits(2) != 0;
    lite_b_valid = b_pending.size() > 0;
    if (lite_b_valid) lite_b_resp = b_pending[0];
    lite_r_valid = r_pending.size() > 0;
    if (lite_r_valid) lite_r = r_pending[0];
  end

  // AXI-Lite memory slave
  always @(posedge clk) begin
    if (lite_b_valid && lite_b_ready) void'(b_pending.pop_front());
    if (lite_r_valid && lite_r_ready) void'(r_pending.pop_front());
    if (lite_aw_valid && lite_aw_ready) waddr_q.push_back(lite_aw_addr);
    if (lite_w_valid && lite_w_ready) wdata_q.push_back(lite_w);
    if (lite_ar_valid && lite_ar_ready) begin
      rd_beat.data = {byte_at(lite_ar_addr | ADDR_W'(1)), byte_at(lite_ar_addr & ~ADDR_W'(1))};
      rd_beat.resp = (lite_ar_addr[ADDR_W-1 -: 4] == 4'hF) ? SLVERR : OKAY;
      r_pending.push_back(rd_beat);
    end
    while (waddr_q.size() > 0 && wdata_q.size() > 0) begin
      wa = waddr_q.pop_front();
      wd = wdata_q.pop_front();
      b_pending.push_back((wa[ADDR_W-1 -: 4] == 4'hF) ? SLVERR : OKAY);
      wa[0] = 1'b0;
      if (wd.strb[0]) mem[wa] = wd.data[7:0];
      if (wd.strb[1]) mem[wa | ADDR_W'(1)] = wd.data[15:8];
    end
  end

  initial begin
    #(40 * 8 * 16 * 20);
    $display("Error: watchdog timeout, the bursts did not complete in time");
    $display("TESTBENCH FAILED");
    $finish;
  end

  initial begin
    axi_ax_t req;
    repeat (10) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    // 20 write bursts, each read back with the same request
    for (int n = 0; n < 20; n++) begin
      make_req(req);
      write_burst(req);
      read_burst(req);
    end
    repeat (5) @(posedge clk);
    done = 1'b1;
    @(posedge clk);
    $display("errors: %0d mismatches, %0d other failures", mismatches, failures);
    if (mismatches == 0 && failures == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

//--- build.f
verilog/axi_axil_pkg.sv
verilog/axi_axil_wr.sv
verilog/axi_axil_rd.sv
verilog/axi_axil_adapter.sv
verification/axi_axil_adapter_chk.sv
verification/axi_axil_monitor.sv
verification/axi_axil_adapter_tb.sv

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module axi_axil_adapter_tb -f build.f &&
  ./obj_dir/Vaxi_axil_adapter_tb | tee /dev/stderr | grep -q "TESTBENCH PASSED" &&
  echo "run.sh: simulation passed" ||
  { echo "run.sh: simulation failed"; exit 1; }
